//--- Makefile
# Verilator build and run of the DMA testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal -j 0
TOP       ?= dma_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir

.PHONY: simulate clean

# Pass only when the run prints the pass line
simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)

//--- sim/dma_cases.txt
# name bus_start buf_start block burst dir err_addr, all values hex
# dir 1 moves buffer to bus, burst length is burst + 1, err_addr ffffffff is none
b2s_basic        00000010 000 010 03 1 ffffffff
b2s_wrap         00000100 1f4 01e 07 1 ffffffff
b2s_uneven       00000040 020 015 04 1 ffffffff
b2s_single       00000200 100 020 00 1 ffffffff
b2s_one_burst    00000300 000 0c8 ff 1 ffffffff
s2b_basic        00000020 040 010 03 0 ffffffff
s2b_wrap         00000080 1fa 014 02 0 ffffffff
s2b_uneven       00000180 080 019 05 0 ffffffff
s2b_big_burst    00000380 180 040 ff 0 ffffffff
b2s_error        00000050 010 020 03 1 0000005a
b2s_after_error  00000050 010 010 03 1 ffffffff
s2b_error_first  00000240 0c0 018 07 0 00000240
s2b_after_error  00000240 0c0 018 07 0 ffffffff
s2b_error_late   00000280 1f0 020 03 0 00000293
b2s_zero_len     00000000 000 000 03 1 ffffffff
s2b_zero_len     00000030 010 000 00 0 ffffffff
b2s_last_word    000003f0 1ff 010 02 1 ffffffff

//--- sim/dma_tb.sv
//##########################################################
// DMA testbench, CPU bus tasks, system memory model,
// compare tasks and the loop over the case file
//##########################################################
`timescale 1ns/10ps

module dma_tb;

    localparam int          sys_words     = 1024;
    localparam int          cpu_ack_limit = 16;
    localparam int          poll_limit    = 5000;
    localparam logic [31:0] lcg_seed      = 32'd18422;

    logic                 clock  = 1'b0;
    logic                 arst_n = 1'b0;
    dma_pkg::dma_wb_req_t cpu_req = '0;
    dma_pkg::dma_wb_rsp_t cpu_rsp;
    dma_pkg::dma_wb_req_t sys_req;
    dma_pkg::dma_wb_rsp_t sys_rsp = '0;

    logic [31:0] sys_mem [sys_words];
    logic [31:0] exp_mem [sys_words];
    logic [31:0] err_addr  = 32'hffff_ffff;
    logic [31:0] data_rng  = lcg_seed;
    logic [31:0] delay_rng = lcg_seed;
    int          wait_left = -1;
    logic        cyc_prev  = 1'b0;
    int          cyc_rises = 0;
    bit          timed_out = 1'b0;
    int          word_errs = 0;
    int          status_errs = 0;
    int          burst_errs = 0;
    int          timeout_errs = 0;
    int          other_errs = 0;

    dma_top i_dut (
        .clock   (clock),
        .arst_n  (arst_n),
        .cpu_req (cpu_req),
        .cpu_rsp (cpu_rsp),
        .sys_req (sys_req),
        .sys_rsp (sys_rsp)
    );

    always #50 clock = ~clock;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic logic [31:0] reg_adr(input logic [2:0] idx);
        return {29'd0, idx};
    endfunction

    function automatic logic [31:0] buffer_cpu_addr(input logic [dma_pkg::dma_buf_aw-1:0] idx);
        return (32'd1 << dma_pkg::cpu_buf_sel_bit) | {23'd0, idx};
    endfunction

    // Readable bits of each configuration register
    function automatic logic [31:0] reg_mask(input int idx);
        case (idx)
            0:       return 32'hffff_ffff;
            1:       return 32'h0000_01ff;
            2:       return 32'h0000_03ff;
            default: return 32'h0000_00ff;
        endcase
    endfunction

    // System memory model with 0 to 3 wait cycles before ack and err at the error address
    always @(negedge clock) begin
        if (sys_req.cyc && !cyc_prev) begin
            cyc_rises++;
        end
        cyc_prev = sys_req.cyc;
        if (sys_rsp.ack || sys_rsp.err) begin
            sys_rsp.ack = 1'b0;
            sys_rsp.err = 1'b0;
            wait_left   = -1;
        end else if (sys_req.cyc && sys_req.stb) begin
            if (wait_left < 0) begin
                delay_rng = lcg_next(delay_rng);
                wait_left = int'(delay_rng[17:16]);
            end
            if (wait_left == 0) begin
                if (sys_req.adr == err_addr) begin
                    sys_rsp.err = 1'b1;
                end else begin
                    sys_rsp.ack = 1'b1;
                    if (sys_req.we) begin
                        sys_mem[sys_req.adr[9:0]] = sys_req.dat;
                    end else begin
                        sys_rsp.dat = sys_mem[sys_req.adr[9:0]];
                    end
                end
            end else begin
                wait_left--;
            end
        end
    end

    task automatic check_word(input string name, input string what,
                              input logic [dma_pkg::dma_data_w-1:0] exp,
                              input logic [dma_pkg::dma_data_w-1:0] act);
        if (act !== exp) begin
            word_errs++;
            $display("FAIL %s %s expected %08h actual %08h", name, what, exp, act);
        end
    endtask

    task automatic check_status(input string name, input dma_pkg::dma_status_t exp,
                                input dma_pkg::dma_status_t act);
        if (act !== exp) begin
            status_errs++;
            $display("FAIL %s status expected error=%0b busy=%0b actual error=%0b busy=%0b",
                     name, exp.error, exp.busy, act.error, act.busy);
        end
    endtask

    task automatic check_cyc_gaps(input string name, input int exp, input int act);
        if (act != exp) begin
            burst_errs++;
            $display("FAIL %s burst count expected %0d actual %0d", name, exp, act);
        end
    endtask

    // One CPU Wishbone classic access held until ack
    task automatic cpu_access(input logic we, input logic [31:0] adr,
                              input logic [31:0] wdat, output logic [31:0] rdat);
        int n;
        rdat = '0;
        if (timed_out) begin
            return;
        end
        @(negedge clock);
        cpu_req.cyc = 1'b1;
        cpu_req.stb = 1'b1;
        cpu_req.we  = we;
        cpu_req.adr = adr;
        cpu_req.dat = wdat;
        n = 0;
        do begin
            @(negedge clock);
            n++;
        end while (!cpu_rsp.ack && !cpu_rsp.err && n < cpu_ack_limit);
        if (cpu_rsp.err !== 1'b0) begin
            $display("CPU port raised err for address %08h", adr);
            other_errs++;
        end
        if (cpu_rsp.ack) begin
            rdat = cpu_rsp.dat;
        end else if (cpu_rsp.err !== 1'b1) begin
            $display("Timeout: no CPU ack for address %08h", adr);
            timeout_errs++;
            timed_out = 1'b1;
        end
        cpu_req = '0;
    endtask

    task automatic cpu_write(input logic [31:0] adr, input logic [31:0] wdat);
        logic [31:0] unused;
        cpu_access(1'b1, adr, wdat, unused);
    endtask

    task automatic cpu_read(input logic [31:0] adr, output logic [31:0] rdat);
        cpu_access(1'b0, adr, '0, rdat);
    endtask

    // Poll busy until the block has finished
    task automatic wait_idle(input string name);
        logic [31:0] rd;
        int          n;
        rd = 32'd1;
        n  = 0;
        while (rd[0] && n < poll_limit && !timed_out) begin
            cpu_read(reg_adr(dma_pkg::reg_ctrl_status), rd);
            n++;
        end
        if (rd[0] && !timed_out) begin
            $display("Timeout: %s still busy after %0d status reads", name, n);
            timeout_errs++;
            timed_out = 1'b1;
        end
    endtask

    task automatic check_registers();
        logic [31:0]          rd;
        dma_pkg::dma_status_t zero_st;
        zero_st = '0;
        cpu_read(reg_adr(dma_pkg::reg_ctrl_status), rd);
        check_status("reset_status", zero_st, dma_pkg::dma_status_t'(rd[1:0]));
        check_word("reset_status", "ctrl word", 32'd0, rd);
        for (int r = 0; r < 4; r++) begin
            cpu_read(reg_adr(3'(r)), rd);
            check_word("reset_regs", $sformatf("reg %0d", r), 32'd0, rd);
        end
        // Only the register width of an all-ones write reads back
        for (int r = 0; r < 4; r++) begin
            cpu_write(reg_adr(3'(r)), 32'hffff_ffff);
        end
        for (int r = 0; r < 4; r++) begin
            cpu_read(reg_adr(3'(r)), rd);
            check_word("reg_readback", $sformatf("reg %0d", r), reg_mask(r), rd);
        end
    endtask

    task automatic run_case(input string name, input logic [31:0] bus_start,
                            input logic [31:0] mem_start, input logic [31:0] block,
                            input logic [31:0] burst, input logic [31:0] dir,
                            input logic [31:0] err_adr);
        logic [31:0]          fill [dma_pkg::dma_buf_depth];
        logic [31:0]          rd;
        logic [31:0]          offs;
        logic [31:0]          exp;
        logic [9:0]           widx;
        dma_pkg::dma_status_t exp_st;
        int                   good;
        int                   tried;
        int                   len;
        int                   rises0;
        bit                   hit;

        for (int i = 0; i < sys_words; i++) begin
            data_rng   = lcg_next(data_rng);
            sys_mem[i] = data_rng;
            exp_mem[i] = data_rng;
        end
        for (int i = 0; i < int'(block); i++) begin
            data_rng = lcg_next(data_rng);
            fill[i]  = data_rng;
            cpu_write(buffer_cpu_addr(9'(mem_start + 32'(i))), fill[i]);
        end
        cpu_write(reg_adr(dma_pkg::reg_bus_start), bus_start);
        cpu_write(reg_adr(dma_pkg::reg_mem_start), mem_start);
        cpu_write(reg_adr(dma_pkg::reg_block_size), block);
        cpu_write(reg_adr(dma_pkg::reg_burst_size), burst);
        err_addr = err_adr;
        rises0   = cyc_rises;
        cpu_write(reg_adr(dma_pkg::reg_ctrl_status), {30'd0, dir[0], 1'b1});
        // Second start with the other direction lands while busy
        if (block != 0) begin
            cpu_write(reg_adr(dma_pkg::reg_ctrl_status), {30'd0, ~dir[0], 1'b1});
        end
        wait_idle(name);
        if (timed_out) begin
            return;
        end

        offs  = err_adr - bus_start;
        hit   = (offs < block);
        tried = hit ? int'(offs) + 1 : int'(block);
        good  = hit ? int'(offs) : int'(block);
        len   = int'(burst) + 1;
        exp_st.error = hit;
        exp_st.busy  = 1'b0;
        cpu_read(reg_adr(dma_pkg::reg_ctrl_status), rd);
        check_status(name, exp_st, dma_pkg::dma_status_t'(rd[1:0]));
        check_cyc_gaps(name, (tried + len - 1) / len, cyc_rises - rises0);

        if (dir[0]) begin
            for (int i = 0; i < good; i++) begin
                widx          = 10'(bus_start + 32'(i));
                exp_mem[widx] = fill[i];
            end
        end
        for (int i = 0; i < sys_words; i++) begin
            check_word(name, $sformatf("mem[%0d]", i), exp_mem[i], sys_mem[i]);
        end
        if (!dir[0]) begin
            for (int i = 0; i < int'(block); i++) begin
                widx = 10'(bus_start + 32'(i));
                exp  = (i < good) ? exp_mem[widx] : fill[i];
                cpu_read(buffer_cpu_addr(9'(mem_start + 32'(i))), rd);
                check_word(name, $sformatf("buffer word %0d", i), exp, rd);
            end
        end
    endtask

    initial begin
        int                fd;
        int                n_cases;
        int                total;
        string             line;
        logic [8*24-1:0]   name_r;
        logic [31:0]       f_bus;
        logic [31:0]       f_mem;
        logic [31:0]       f_block;
        logic [31:0]       f_burst;
        logic [31:0]       f_dir;
        logic [31:0]       f_err;

        n_cases = 0;
        cpu_req = '0;
        arst_n  = 1'b0;
        repeat (4) @(posedge clock);
        @(negedge clock);
        arst_n = 1'b1;

        check_registers();

        fd = $fopen("sim/dma_cases.txt", "r");
        if (fd == 0) begin
            $display("Could not open the case file sim/dma_cases.txt");
            other_errs++;
        end else begin
            while (!timed_out && $fgets(line, fd) != 0) begin
                if (line.len() > 1 && line[0] != "#") begin
                    if ($sscanf(line, "%s %h %h %h %h %h %h", name_r, f_bus, f_mem,
                                f_block, f_burst, f_dir, f_err) == 7) begin
                        run_case($sformatf("%0s", name_r), f_bus, f_mem, f_block,
                                 f_burst, f_dir, f_err);
                        n_cases++;
                    end
                end
            end
            $fclose(fd);
        end
        if (n_cases == 0) begin
            $display("No transfer cases were read from the case file");
            other_errs++;
        end

        total = word_errs + status_errs + burst_errs + timeout_errs + other_errs;
        $display("Errors: data %0d, status %0d, burst %0d, timeout %0d, other %0d",
                 word_errs, status_errs, burst_errs, timeout_errs, other_errs);
        if (total == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- source/dma_addr_gen.sv
//##########################################################
// Bus and buffer address counters, remaining word count
// and position within the current burst
//##########################################################
`timescale 1ns/10ps

module dma_addr_gen (
    input  logic                           clock,
    input  logic                           arst_n,
    input  dma_pkg::dma_cfg_t              cfg,
    input  logic                           load,
    input  logic                           advance,
    input  logic                           burst_start,
    output logic [31:0]                    bus_addr,
    output logic [dma_pkg::dma_buf_aw-1:0] buf_addr,
    output logic                           last_word,
    output logic                           burst_end
);

    logic [dma_pkg::dma_block_w-1:0] remaining;
    logic [dma_pkg::dma_burst_w-1:0] burst_cnt;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            bus_addr  <= '0;
            buf_addr  <= '0;
            remaining <= '0;
            burst_cnt <= '0;
        end else if (load) begin
            bus_addr  <= cfg.bus_start;
            buf_addr  <= cfg.mem_start;
            remaining <= cfg.block_size;
            burst_cnt <= '0;
        end else if (advance) begin
            bus_addr  <= bus_addr + 32'd1;
            // 9-bit counter, wraps at the buffer end
            buf_addr  <= buf_addr + 1'b1;
            remaining <= remaining - 1'b1;
            burst_cnt <= burst_cnt + 1'b1;
        end else if (burst_start) begin
            burst_cnt <= '0;
        end
    end

    // Flags describe the word at the current addresses
    assign last_word = (remaining == {{(dma_pkg::dma_block_w-1){1'b0}}, 1'b1});
    assign burst_end = (burst_cnt == cfg.burst_size);

endmodule

//--- source/dma_buffer_ram.sv
//##########################################################
// Dual-port 512 x 32 buffer, synchronous reads
//##########################################################
`timescale 1ns/10ps

module dma_buffer_ram (
    input  logic                           clock,
    input  logic [dma_pkg::dma_buf_aw-1:0] a_addr,
    input  logic                           a_we,
    input  logic [dma_pkg::dma_data_w-1:0] a_wdata,
    output logic [dma_pkg::dma_data_w-1:0] a_rdata,
    input  logic [dma_pkg::dma_buf_aw-1:0] b_addr,
    input  logic                           b_we,
    input  logic [dma_pkg::dma_data_w-1:0] b_wdata,
    output logic [dma_pkg::dma_data_w-1:0] b_rdata
);

    logic [dma_pkg::dma_data_w-1:0] mem [dma_pkg::dma_buf_depth];

    // Port A, CPU side
    always_ff @(posedge clock) begin
        if (a_we) begin
            mem[a_addr] <= a_wdata;
        end
        a_rdata <= mem[a_addr];
    end

    // Port B, DMA side
    always_ff @(posedge clock) begin
        if (b_we) begin
            mem[b_addr] <= b_wdata;
        end
        b_rdata <= mem[b_addr];
    end

endmodule

//--- source/dma_bus_master.sv
//##########################################################
// Wishbone classic master, one word per request
//##########################################################
`timescale 1ns/10ps

module dma_bus_master (
    input  logic                           clock,
    input  logic                           arst_n,
    input  logic                           word_req,
    input  logic                           we,
    input  logic [31:0]                    addr,
    input  logic [dma_pkg::dma_data_w-1:0] wdata,
    input  logic                           hold_cyc,
    output dma_pkg::dma_wb_req_t           sys_req,
    input  dma_pkg::dma_wb_rsp_t           sys_rsp,
    output logic [dma_pkg::dma_data_w-1:0] rdata,
    output logic                           word_done,
    output logic                           word_err
);

    logic                           cyc_q;
    logic                           stb_q;
    logic                           we_q;
    logic [31:0]                    adr_q;
    logic [dma_pkg::dma_data_w-1:0] dat_q;

    assign word_done = stb_q & sys_rsp.ack;
    assign word_err  = stb_q & sys_rsp.err;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            cyc_q <= 1'b0;
            stb_q <= 1'b0;
            we_q  <= 1'b0;
        end else if (word_req) begin
            cyc_q <= 1'b1;
            stb_q <= 1'b1;
            we_q  <= we;
        end else if (word_err) begin
            cyc_q <= 1'b0;
            stb_q <= 1'b0;
        end else if (word_done) begin
            stb_q <= 1'b0;
            // cyc carries over to the next word of the burst
            cyc_q <= hold_cyc;
        end
    end

    // Address and data held until ack or err
    always_ff @(posedge clock) begin
        if (word_req) begin
            adr_q <= addr;
            dat_q <= wdata;
        end
        if (word_done && !we_q) begin
            rdata <= sys_rsp.dat;
        end
    end

    assign sys_req.cyc = cyc_q;
    assign sys_req.stb = stb_q;
    assign sys_req.we  = we_q;
    assign sys_req.adr = adr_q;
    assign sys_req.dat = dat_q;

endmodule

//--- source/dma_control.sv
//##########################################################
// Block, burst and word sequencing FSM, busy and error
//##########################################################
`timescale 1ns/10ps

module dma_control (
    input  logic                 clock,
    input  logic                 arst_n,
    input  logic                 start,
    input  dma_pkg::dma_cfg_t    cfg,
    input  logic                 last_word,
    input  logic                 burst_end,
    input  logic                 word_done,
    input  logic                 word_err,
    output logic                 load,
    output logic                 advance,
    output logic                 burst_start,
    output logic                 word_req,
    output logic                 hold_cyc,
    output logic                 buf_we,
    output dma_pkg::dma_status_t status
);

    typedef enum logic [2:0] {
        st_idle,
        st_fetch,
        st_word,
        st_gap,
        st_finish
    } state_t;

    state_t state;
    state_t state_next;
    state_t step_next;
    logic   error_q;
    logic   req_pend;

    // Where to go once a word and its buffer step are done
    assign step_next = last_word ? st_finish
                     : burst_end ? st_gap
                     : cfg.dir   ? st_fetch : st_word;

    // Buffer to bus reads in fetch before the word,
    // bus to buffer writes in fetch after the word
    always_comb begin
        state_next = state;
        case (state)
            st_idle: begin
                if (start) begin
                    state_next = (cfg.block_size == '0) ? st_finish : st_gap;
                end
            end
            st_gap: begin
                state_next = cfg.dir ? st_fetch : st_word;
            end
            st_fetch: begin
                state_next = cfg.dir ? st_word : step_next;
            end
            st_word: begin
                if (word_err) begin
                    state_next = st_idle;
                end else if (word_done) begin
                    state_next = cfg.dir ? step_next : st_fetch;
                end
            end
            st_finish: begin
                state_next = st_idle;
            end
            default: begin
                state_next = st_idle;
            end
        endcase
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state    <= st_idle;
            error_q  <= 1'b0;
            req_pend <= 1'b0;
        end else begin
            state    <= state_next;
            req_pend <= (state_next == st_word) && (state != st_word);
            if (load) begin
                error_q <= 1'b0;
            end else if (state == st_word && word_err) begin
                error_q <= 1'b1;
            end
        end
    end

    assign load        = start && (state == st_idle);
    assign advance     = cfg.dir ? (state == st_word && word_done) : (state == st_fetch);
    assign burst_start = (state == st_gap);
    assign buf_we      = (state == st_fetch) && !cfg.dir;
    assign word_req    = req_pend;
    // Sampled by the bus master on ack only
    assign hold_cyc    = !(last_word || burst_end);

    assign status.busy  = (state != st_idle);
    assign status.error = error_q;

endmodule

//--- source/dma_pkg.sv
//##########################################################
// Shared widths, CPU register map, Wishbone request and
// response types, configuration and control word types
//##########################################################
package dma_pkg;

    // Datapath and buffer geometry
    localparam int dma_data_w    = 32;
    localparam int dma_buf_depth = 512;
    localparam int dma_buf_aw    = 9;
    localparam int dma_block_w   = 10;
    localparam int dma_burst_w   = 8;

    // CPU register map, word addresses
    localparam logic [2:0] reg_bus_start   = 3'd0;
    localparam logic [2:0] reg_mem_start   = 3'd1;
    localparam logic [2:0] reg_block_size  = 3'd2;
    localparam logic [2:0] reg_burst_size  = 3'd3;
    localparam logic [2:0] reg_ctrl_status = 3'd4;

    // Address bit that steers CPU accesses into the buffer
    localparam int cpu_buf_sel_bit = 10;

    typedef struct packed {
        logic                  cyc;
        logic                  stb;
        logic                  we;
        logic [31:0]           adr;
        logic [dma_data_w-1:0] dat;
    } dma_wb_req_t;

    typedef struct packed {
        logic                  ack;
        logic                  err;
        logic [dma_data_w-1:0] dat;
    } dma_wb_rsp_t;

    typedef struct packed {
        logic [31:0]            bus_start;
        logic [dma_buf_aw-1:0]  mem_start;
        logic [dma_block_w-1:0] block_size;
        logic [dma_burst_w-1:0] burst_size;
        logic                   dir;        // 1 moves buffer to bus
    } dma_cfg_t;

    typedef struct packed {
        logic [29:0] rsvd;
        logic        dir;
        logic        start;
    } dma_ctrl_t;

    // CPU write word, raw value or control fields
    typedef union packed {
        logic [dma_data_w-1:0] raw;
        dma_ctrl_t             ctrl;
    } dma_cfg_word_u;

    typedef struct packed {
        logic error;
        logic busy;
    } dma_status_t;

endpackage

//--- source/dma_reg_file.sv
//##########################################################
// CPU Wishbone slave with configuration and status
// registers and the CPU path into the buffer
//##########################################################
`timescale 1ns/10ps

module dma_reg_file (
    input  logic                           clock,
    input  logic                           arst_n,
    input  dma_pkg::dma_wb_req_t           cpu_req,
    output dma_pkg::dma_wb_rsp_t           cpu_rsp,
    output dma_pkg::dma_cfg_t              cfg,
    output logic                           start,
    input  dma_pkg::dma_status_t           status,
    output logic [dma_pkg::dma_buf_aw-1:0] buf_addr,
    output logic                           buf_we,
    output logic [dma_pkg::dma_data_w-1:0] buf_wdata,
    input  logic [dma_pkg::dma_data_w-1:0] buf_rdata
);

    dma_pkg::dma_cfg_word_u         wdata_u;
    dma_pkg::dma_cfg_t              cfg_q;
    logic                           ack_q;
    logic                           buf_sel;
    logic                           buf_sel_q;
    logic                           access;
    logic                           reg_wr;
    logic [2:0]                     reg_idx;
    logic [dma_pkg::dma_data_w-1:0] reg_rdata;
    logic [dma_pkg::dma_data_w-1:0] reg_rdata_q;

    assign wdata_u.raw = cpu_req.dat;
    assign buf_sel     = cpu_req.adr[dma_pkg::cpu_buf_sel_bit];
    assign reg_idx     = cpu_req.adr[2:0];

    // Ack cycle closes the strobe, so it is not a second access
    assign access = cpu_req.cyc & cpu_req.stb & ~ack_q;
    assign reg_wr = access & cpu_req.we & ~buf_sel;

    // Buffer port A, RAM data lines up with the ack
    assign buf_addr  = cpu_req.adr[dma_pkg::dma_buf_aw-1:0];
    assign buf_we    = access & cpu_req.we & buf_sel;
    assign buf_wdata = cpu_req.dat;

    // Start pulse, dropped while a block is running
    assign start = reg_wr & (reg_idx == dma_pkg::reg_ctrl_status)
                 & wdata_u.ctrl.start & ~status.busy;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            ack_q <= 1'b0;
            cfg_q <= '0;
        end else begin
            ack_q <= access;
            if (reg_wr) begin
                case (reg_idx)
                    dma_pkg::reg_bus_start: begin
                        cfg_q.bus_start <= wdata_u.raw;
                    end
                    dma_pkg::reg_mem_start: begin
                        cfg_q.mem_start <= wdata_u.raw[dma_pkg::dma_buf_aw-1:0];
                    end
                    dma_pkg::reg_block_size: begin
                        cfg_q.block_size <= wdata_u.raw[dma_pkg::dma_block_w-1:0];
                    end
                    dma_pkg::reg_burst_size: begin
                        cfg_q.burst_size <= wdata_u.raw[dma_pkg::dma_burst_w-1:0];
                    end
                    dma_pkg::reg_ctrl_status: begin
                        // Direction stays fixed during a block
                        if (!status.busy) begin
                            cfg_q.dir <= wdata_u.ctrl.dir;
                        end
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // Register read mux, zero extended
    always_comb begin
        reg_rdata = '0;
        case (reg_idx)
            dma_pkg::reg_bus_start:   reg_rdata = cfg_q.bus_start;
            dma_pkg::reg_mem_start:   reg_rdata[dma_pkg::dma_buf_aw-1:0] = cfg_q.mem_start;
            dma_pkg::reg_block_size:  reg_rdata[dma_pkg::dma_block_w-1:0] = cfg_q.block_size;
            dma_pkg::reg_burst_size:  reg_rdata[dma_pkg::dma_burst_w-1:0] = cfg_q.burst_size;
            dma_pkg::reg_ctrl_status: reg_rdata[1:0] = status;
            default:                  reg_rdata = '0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (access) begin
            buf_sel_q   <= buf_sel;
            reg_rdata_q <= reg_rdata;
        end
    end

    assign cpu_rsp.ack = ack_q;
    assign cpu_rsp.err = 1'b0;
    assign cpu_rsp.dat = buf_sel_q ? buf_rdata : reg_rdata_q;
    assign cfg         = cfg_q;

endmodule

//--- source/dma_top.sv
//##########################################################
// DMA engine top, register file, buffer, address
// generator, bus master and sequencing FSM
//##########################################################
`timescale 1ns/10ps

module dma_top (
    input  logic                 clock,
    input  logic                 arst_n,
    input  dma_pkg::dma_wb_req_t cpu_req,
    output dma_pkg::dma_wb_rsp_t cpu_rsp,
    output dma_pkg::dma_wb_req_t sys_req,
    input  dma_pkg::dma_wb_rsp_t sys_rsp
);

    dma_pkg::dma_cfg_t              cfg;
    dma_pkg::dma_status_t           status;
    logic                           start;
    logic [dma_pkg::dma_buf_aw-1:0] cpu_buf_addr;
    logic                           cpu_buf_we;
    logic [dma_pkg::dma_data_w-1:0] cpu_buf_wdata;
    logic [dma_pkg::dma_data_w-1:0] cpu_buf_rdata;
    logic [dma_pkg::dma_buf_aw-1:0] dma_buf_addr;
    logic                           dma_buf_we;
    logic [dma_pkg::dma_data_w-1:0] dma_buf_rdata;
    logic [dma_pkg::dma_data_w-1:0] bus_rdata;
    logic [31:0]                    bus_addr;
    logic                           load;
    logic                           advance;
    logic                           burst_start;
    logic                           last_word;
    logic                           burst_end;
    logic                           word_req;
    logic                           hold_cyc;
    logic                           word_done;
    logic                           word_err;

    dma_reg_file i_reg_file (
        .clock     (clock),
        .arst_n    (arst_n),
        .cpu_req   (cpu_req),
        .cpu_rsp   (cpu_rsp),
        .cfg       (cfg),
        .start     (start),
        .status    (status),
        .buf_addr  (cpu_buf_addr),
        .buf_we    (cpu_buf_we),
        .buf_wdata (cpu_buf_wdata),
        .buf_rdata (cpu_buf_rdata)
    );

    dma_buffer_ram i_buffer_ram (
        .clock   (clock),
        .a_addr  (cpu_buf_addr),
        .a_we    (cpu_buf_we),
        .a_wdata (cpu_buf_wdata),
        .a_rdata (cpu_buf_rdata),
        .b_addr  (dma_buf_addr),
        .b_we    (dma_buf_we),
        .b_wdata (bus_rdata),
        .b_rdata (dma_buf_rdata)
    );

    dma_addr_gen i_addr_gen (
        .clock       (clock),
        .arst_n      (arst_n),
        .cfg         (cfg),
        .load        (load),
        .advance     (advance),
        .burst_start (burst_start),
        .bus_addr    (bus_addr),
        .buf_addr    (dma_buf_addr),
        .last_word   (last_word),
        .burst_end   (burst_end)
    );

    dma_bus_master i_bus_master (
        .clock     (clock),
        .arst_n    (arst_n),
        .word_req  (word_req),
        .we        (cfg.dir),
        .addr      (bus_addr),
        .wdata     (dma_buf_rdata),
        .hold_cyc  (hold_cyc),
        .sys_req   (sys_req),
        .sys_rsp   (sys_rsp),
        .rdata     (bus_rdata),
        .word_done (word_done),
        .word_err  (word_err)
    );

    dma_control i_control (
        .clock       (clock),
        .arst_n      (arst_n),
        .start       (start),
        .cfg         (cfg),
        .last_word   (last_word),
        .burst_end   (burst_end),
        .word_done   (word_done),
        .word_err    (word_err),
        .load        (load),
        .advance     (advance),
        .burst_start (burst_start),
        .word_req    (word_req),
        .hold_cyc    (hold_cyc),
        .buf_we      (dma_buf_we),
        .status      (status)
    );

endmodule

//--- src.f
source/dma_pkg.sv
source/dma_buffer_ram.sv
source/dma_reg_file.sv
source/dma_addr_gen.sv
source/dma_bus_master.sv
source/dma_control.sv
source/dma_top.sv
sim/dma_tb.sv
